// File: logic/md_ctrl.sv
`timescale 1ns/1ps

module md_ctrl import md_pkg::*; #(
	parameter int WIDTH = MD_WIDTH_DEF
) (
	input  logic                     clk_i,
	input  logic                     rst_ni,
	input  logic                     start_i,
	input  md_op_e                   operator_i,
	input  md_op_e                   op_latched_i,
	input  logic                     div_zero_i,
	output logic                     accept_o,
	output md_state_e                state_o,
	output logic [$clog2(WIDTH)-1:0] count_o,
	output logic                     valid_o,
	output logic                     busy_o
);

	localparam int CW = $clog2(WIDTH);

	md_state_e        state_q;
	md_state_e        state_d;
	logic [CW-1:0]    count_q;
	logic [CW-1:0]    count_d;
	logic             is_mul;

	assign is_mul   = (op_latched_i == MD_OP_MULL);
	assign accept_o = start_i && (state_q == MD_IDLE) && (operator_i != md_op_e'(2'b01));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next state and iteration counter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		state_d = state_q;
		count_d = count_q;
		case (state_q)
			MD_IDLE: begin
				if (accept_o) begin
					state_d = MD_INIT;
				end
			end
			MD_INIT: begin
				count_d = CW'(WIDTH - 1);
				if (is_mul) begin
					state_d = MD_COMP;
				end else if (div_zero_i) begin
					state_d = MD_FINISH;  // result already loaded
				end else begin
					state_d = MD_ABS_A;
				end
			end
			MD_ABS_A:       state_d = MD_ABS_B;
			MD_ABS_B:       state_d = MD_COMP;
			MD_COMP: begin
				count_d = count_q - CW'(1);
				if (count_q == CW'(1)) begin
					state_d = MD_LAST;
				end
			end
			MD_LAST:        state_d = is_mul ? MD_IDLE : MD_CHANGE_SIGN;
			MD_CHANGE_SIGN: state_d = MD_FINISH;
			default:        state_d = MD_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= MD_IDLE;
			count_q <= '0;
		end else begin
			state_q <= state_d;
			count_q <= count_d;
		end
	end

	assign state_o = state_q;
	assign count_o = count_q;
	assign busy_o  = (state_q != MD_IDLE);
	assign valid_o = (state_q == MD_FINISH) || ((state_q == MD_LAST) && is_mul);

endmodule

// File: logic/md_datapath.sv
`timescale 1ns/1ps

module md_datapath import md_pkg::*; #(
	parameter int WIDTH = MD_WIDTH_DEF
) (
	input  logic                     clk_i,
	input  logic                     rst_ni,
	input  md_state_e                state_i,
	input  logic [$clog2(WIDTH)-1:0] count_i,
	input  md_op_e                   operator_i,
	input  logic [WIDTH-1:0]         op_a_i,
	input  logic [WIDTH-1:0]         op_b_i,
	input  logic                     sign_a_i,
	input  logic                     sign_b_i,
	output logic [WIDTH-1:0]         result_o
);

	localparam int CW = $clog2(WIDTH);

	logic [WIDTH:0]   accum_q;
	logic [WIDTH:0]   accum_d;
	logic [WIDTH:0]   op_a_shift_q;  // multiplicand, or quotient while dividing
	logic [WIDTH:0]   op_a_shift_d;
	logic [WIDTH:0]   op_b_shift_q;  // multiplier, or divisor magnitude
	logic [WIDTH:0]   op_b_shift_d;
	logic [WIDTH-1:0] numerator_q;
	logic [WIDTH-1:0] numerator_d;

	logic [WIDTH:0]   adder_a;
	logic [WIDTH:0]   adder_b;
	logic             adder_cin;
	logic [WIDTH+1:0] adder_sum;

	logic             is_mul;
	logic             neg_result;
	logic             is_greater_equal;
	logic [WIDTH:0]   op_a_ext;
	logic [WIDTH:0]   op_b_ext;
	logic [WIDTH:0]   pp;
	logic [WIDTH:0]   one_shift;
	logic [WIDTH:0]   next_quotient;
	logic [WIDTH-1:0] next_remainder;
	logic [CW-1:0]    count_m1;

	assign is_mul   = (operator_i == MD_OP_MULL);
	assign op_a_ext = {sign_a_i, op_a_i};
	assign op_b_ext = {sign_b_i, op_b_i};
	assign count_m1 = count_i - CW'(1);

	// current partial product
	assign pp = op_a_shift_q & {(WIDTH+1){op_b_shift_q[0]}};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// adder and operand selection
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		adder_a   = accum_q;
		adder_b   = pp;
		adder_cin = 1'b0;
		if (!is_mul) begin
			adder_cin = 1'b1;  // two's complement forms below
			case (state_i)
				MD_ABS_A: begin
					adder_a = '0;
					adder_b = ~{1'b0, op_a_i};
				end
				MD_ABS_B: begin
					adder_a = '0;
					adder_b = ~{1'b0, op_b_i};
				end
				MD_CHANGE_SIGN: begin
					adder_a = '0;
					adder_b = ~{1'b0, accum_q[WIDTH-1:0]};
				end
				default: begin
					adder_b = ~{1'b0, op_b_shift_q[WIDTH-1:0]};  // remainder minus divisor
				end
			endcase
		end
	end

	assign adder_sum = {1'b0, adder_a} + {1'b0, adder_b} + {{(WIDTH+1){1'b0}}, adder_cin};

	// carry out means no borrow
	assign is_greater_equal = adder_sum[WIDTH+1];
	assign one_shift        = {{WIDTH{1'b0}}, 1'b1} << count_i;
	assign next_remainder   = is_greater_equal ? adder_sum[WIDTH-1:0] : accum_q[WIDTH-1:0];
	assign next_quotient    = is_greater_equal ? (op_a_shift_q | one_shift) : op_a_shift_q;
	assign neg_result       = (operator_i == MD_OP_DIV) ? (sign_a_i ^ sign_b_i) : sign_a_i;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register updates per state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		accum_d      = accum_q;
		op_a_shift_d = op_a_shift_q;
		op_b_shift_d = op_b_shift_q;
		numerator_d  = numerator_q;
		case (state_i)
			MD_INIT: begin
				case (operator_i)
					MD_OP_MULL: begin
						op_a_shift_d = op_a_ext << 1;
						op_b_shift_d = op_b_ext >> 1;
						accum_d      = op_a_ext & {(WIDTH+1){op_b_i[0]}};
					end
					MD_OP_DIV: accum_d = '1;  // zero divisor result
					default:   accum_d = op_a_ext;
				endcase
			end
			MD_ABS_A: begin
				op_a_shift_d = '0;
				numerator_d  = sign_a_i ? adder_sum[WIDTH-1:0] : op_a_i;
			end
			MD_ABS_B: begin
				accum_d      = {{WIDTH{1'b0}}, numerator_q[WIDTH-1]};
				op_b_shift_d = {1'b0, (sign_b_i ? adder_sum[WIDTH-1:0] : op_b_i)};
			end
			MD_COMP: begin
				if (is_mul) begin
					accum_d      = adder_sum[WIDTH:0];
					op_a_shift_d = op_a_shift_q << 1;
					op_b_shift_d = op_b_shift_q >> 1;
				end else begin
					accum_d      = {next_remainder, numerator_q[count_m1]};  // bring down next bit
					op_a_shift_d = next_quotient;
				end
			end
			MD_LAST: begin
				if (is_mul) begin
					accum_d = adder_sum[WIDTH:0];
				end else if (operator_i == MD_OP_DIV) begin
					accum_d = next_quotient;
				end else begin
					accum_d = {1'b0, next_remainder};
				end
			end
			MD_CHANGE_SIGN: begin
				if (neg_result) begin
					accum_d = adder_sum[WIDTH:0];
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			accum_q <= '0;
		end else begin
			accum_q <= accum_d;
		end
	end

	always_ff @(posedge clk_i) begin
		op_a_shift_q <= op_a_shift_d;
		op_b_shift_q <= op_b_shift_d;
		numerator_q  <= numerator_d;
	end

	assign result_o = accum_q[WIDTH-1:0];

endmodule

// File: logic/md_op_regs.sv
`timescale 1ns/1ps

module md_op_regs import md_pkg::*; #(
	parameter int WIDTH = MD_WIDTH_DEF
) (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  logic             load_i,
	input  md_op_e           operator_i,
	input  logic [1:0]       signed_mode_i,
	input  logic [WIDTH-1:0] op_a_i,
	input  logic [WIDTH-1:0] op_b_i,
	output md_op_e           operator_o,
	output logic [WIDTH-1:0] op_a_o,
	output logic [WIDTH-1:0] op_b_o,
	output logic             sign_a_o,
	output logic             sign_b_o,
	output logic             div_zero_o
);

	md_op_e           operator_q;
	logic             sign_a_q;
	logic             sign_b_q;
	logic             div_zero_q;
	logic [WIDTH-1:0] op_a_q;
	logic [WIDTH-1:0] op_b_q;

	// configuration of the running operation
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			operator_q <= MD_OP_MULL;
			sign_a_q   <= 1'b0;
			sign_b_q   <= 1'b0;
			div_zero_q <= 1'b0;
		end else if (load_i) begin
			operator_q <= operator_i;
			sign_a_q   <= op_a_i[WIDTH-1] & signed_mode_i[0];  // negative only if signed
			sign_b_q   <= op_b_i[WIDTH-1] & signed_mode_i[1];
			div_zero_q <= (op_b_i == '0);
		end
	end

	always_ff @(posedge clk_i) begin
		if (load_i) begin
			op_a_q <= op_a_i;
			op_b_q <= op_b_i;
		end
	end

	assign operator_o = operator_q;
	assign op_a_o     = op_a_q;
	assign op_b_o     = op_b_q;
	assign sign_a_o   = sign_a_q;
	assign sign_b_o   = sign_b_q;
	assign div_zero_o = div_zero_q;

endmodule

// File: logic/md_pkg.sv
package md_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operator encoding, code 1 is reserved
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [1:0] {
		MD_OP_MULL = 2'd0,  // low word of product
		MD_OP_DIV  = 2'd2,  // quotient
		MD_OP_REM  = 2'd3   // remainder
	} md_op_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequencer states
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {
		MD_IDLE        = 3'd0,
		MD_INIT        = 3'd1,  // load operands into the datapath
		MD_ABS_A       = 3'd2,
		MD_ABS_B       = 3'd3,
		MD_COMP        = 3'd4,  // one result bit per cycle
		MD_LAST        = 3'd5,
		MD_CHANGE_SIGN = 3'd6,
		MD_FINISH      = 3'd7
	} md_state_e;

	localparam int MD_WIDTH_DEF = 32;  // default operand width

endpackage

// File: logic/md_serial_unit.sv
`timescale 1ns/1ps

module md_serial_unit import md_pkg::*; #(
	parameter int WIDTH = MD_WIDTH_DEF
) (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  logic             start_i,
	input  md_op_e           operator_i,
	input  logic [1:0]       signed_mode_i,
	input  logic [WIDTH-1:0] op_a_i,
	input  logic [WIDTH-1:0] op_b_i,
	output logic [WIDTH-1:0] result_o,
	output logic             valid_o,
	output logic             busy_o
);

	localparam int CW = $clog2(WIDTH);

	logic             accept;
	md_op_e           operator_q;
	logic [WIDTH-1:0] op_a_q;
	logic [WIDTH-1:0] op_b_q;
	logic             sign_a;
	logic             sign_b;
	logic             div_zero;
	md_state_e        state;
	logic [CW-1:0]    count;

	md_op_regs #(.WIDTH(WIDTH)) md_op_regs_inst (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.load_i        (accept),
		.operator_i    (operator_i),
		.signed_mode_i (signed_mode_i),
		.op_a_i        (op_a_i),
		.op_b_i        (op_b_i),
		.operator_o    (operator_q),
		.op_a_o        (op_a_q),
		.op_b_o        (op_b_q),
		.sign_a_o      (sign_a),
		.sign_b_o      (sign_b),
		.div_zero_o    (div_zero)
	);

	md_ctrl #(.WIDTH(WIDTH)) md_ctrl_inst (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.start_i      (start_i),
		.operator_i   (operator_i),  // raw code, reserved one refused
		.op_latched_i (operator_q),
		.div_zero_i   (div_zero),
		.accept_o     (accept),
		.state_o      (state),
		.count_o      (count),
		.valid_o      (valid_o),
		.busy_o       (busy_o)
	);

	md_datapath #(.WIDTH(WIDTH)) md_datapath_inst (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.state_i    (state),
		.count_i    (count),
		.operator_i (operator_q),
		.op_a_i     (op_a_q),
		.op_b_i     (op_b_q),
		.sign_a_i   (sign_a),
		.sign_b_i   (sign_b),
		.result_o   (result_o)
	);

endmodule

// File: md_serial_unit.f
+incdir+include
logic/md_pkg.sv
logic/md_op_regs.sv
logic/md_ctrl.sv
logic/md_datapath.sv
logic/md_serial_unit.sv
verification/md_serial_unit_tb.sv

// File: include/md_ref.svh
`ifndef MD_REF_SVH
`define MD_REF_SVH

// expected result of one 32-bit operation
function automatic logic [31:0] md_ref(
	input md_pkg::md_op_e operator,
	input logic [1:0]     signed_mode,
	input logic [31:0]    op_a,
	input logic [31:0]    op_b
);
	logic signed [63:0] a_ext;
	logic signed [63:0] b_ext;
	logic signed [63:0] res;

	a_ext = signed_mode[0] ? {{32{op_a[31]}}, op_a} : {32'b0, op_a};
	b_ext = signed_mode[1] ? {{32{op_b[31]}}, op_b} : {32'b0, op_b};
	res   = '0;
	case (operator)
		md_pkg::MD_OP_MULL: res = a_ext * b_ext;
		md_pkg::MD_OP_DIV: begin
			if (op_b == '0) begin
				res = '1;  // divide by zero gives all ones
			end else begin
				res = a_ext / b_ext;  // truncates, overflow case wraps
			end
		end
		md_pkg::MD_OP_REM: begin
			if (op_b == '0) begin
				res = a_ext;
			end else begin
				res = a_ext % b_ext;  // sign follows dividend
			end
		end
		default: res = '0;
	endcase
	return res[31:0];
endfunction

`endif

// File: verification/md_serial_unit_tb.sv
`timescale 1ns/1ps

module md_serial_unit_tb import md_pkg::*; ();

	localparam int MUL_OPS    = 56;
	localparam int DIV_OPS    = 24;
	localparam int CORNER_OPS = 6;
	localparam int IGNORE_OPS = 2;  // one ignored start, one reserved code
	localparam int HOLD_OPS   = 4;
	localparam int TOTAL_OPS  = MUL_OPS + DIV_OPS + CORNER_OPS + IGNORE_OPS + HOLD_OPS;
	localparam int TIMEOUT_CYCLES = 40 * TOTAL_OPS + 100;

	logic        clk_i;
	logic        rst_ni;
	logic        start_i;
	md_op_e      operator_i;
	logic [1:0]  signed_mode_i;
	logic [31:0] op_a_i;
	logic [31:0] op_b_i;
	logic [31:0] result_o;
	logic        valid_o;
	logic        busy_o;

	integer      seed;
	int          cycle_cnt = 0;
	int          pass_cnt = 0;
	int          fail_cnt = 0;
	int          issued_cnt = 0;
	int          done_cnt = 0;
	logic [31:0] exp_q[$];  // pending operations, oldest first
	int          lat_q[$];
	int          start_q[$];
	string       name_q[$];
	logic [31:0] fixed_a [4] = '{32'h0000_0000, 32'h0000_0001, 32'h8000_0000, 32'h7fff_ffff};
	logic [31:0] fixed_b [4] = '{32'h0000_0005, 32'hffff_ffff, 32'hffff_ffff, 32'h7fff_ffff};

	`include "md_ref.svh"

	md_serial_unit #(.WIDTH(32)) md_serial_unit_inst (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.start_i       (start_i),
		.operator_i    (operator_i),
		.signed_mode_i (signed_mode_i),
		.op_a_i        (op_a_i),
		.op_b_i        (op_b_i),
		.result_o      (result_o),
		.valid_o       (valid_o),
		.busy_o        (busy_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("TIMEOUT: stopped after %0d cycles, valid_o never arrived", cycle_cnt);
		$display("Test failures found");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic int latency_of(input md_op_e op, input logic [31:0] b);
		if (op == MD_OP_MULL) begin
			return 33;
		end else if (b == '0) begin
			return 2;  // loop skipped
		end
		return 37;
	endfunction

	task automatic check_eq(input logic [31:0] expected, input logic [31:0] actual,
			input string msg);
		if (actual !== expected) begin
			$display("MISMATCH at time %0t: %s, expected %h, got %h",
				$time, msg, expected, actual);
			fail_cnt++;
		end else begin
			pass_cnt++;
		end
	endtask

	task automatic scramble_inputs();
		op_a_i        = $random(seed);
		op_b_i        = $random(seed);
		signed_mode_i = 2'($random(seed));
		operator_i    = md_op_e'(2'($random(seed)));
	endtask

	task automatic issue_op(input md_op_e op, input logic [1:0] mode, input logic [31:0] a,
			input logic [31:0] b, input string name);
		@(posedge clk_i);
		#1;
		start_i       = 1'b1;
		operator_i    = op;
		signed_mode_i = mode;
		op_a_i        = a;
		op_b_i        = b;
		exp_q.push_back(md_ref(op, mode, a, b));
		lat_q.push_back(latency_of(op, b));
		start_q.push_back(cycle_cnt);
		name_q.push_back(name);
		issued_cnt++;
		@(posedge clk_i);
		#1;
		start_i = 1'b0;
		scramble_inputs();  // DUT must not need them any more
	endtask

	task automatic wait_done();
		wait (done_cnt == issued_cnt);
	endtask

	task automatic report_test(input string name, input int fails_before);
		$display("test %s: %s, %0d failures", name,
			(fail_cnt == fails_before) ? "ok" : "FAILED", fail_cnt - fails_before);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// comparing process
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(negedge clk_i) begin : compare_results
		string       name;
		logic [31:0] expected;
		int          latency;
		int          started;
		if (rst_ni && valid_o) begin
			if (exp_q.size() == 0) begin
				$display("ERROR at time %0t: valid_o raised with no operation pending", $time);
				fail_cnt++;
			end else begin
				expected = exp_q.pop_front();
				latency  = lat_q.pop_front();
				started  = start_q.pop_front();
				name     = name_q.pop_front();
				check_eq(expected, result_o, name);
				check_eq(latency, cycle_cnt - started, {name, " latency"});
				done_cnt++;
			end
		end
	end

	initial begin : main
		int          fails_before;
		logic        seen;
		logic [31:0] a;
		logic [31:0] b;
		md_op_e      op;
		seed          = 57;
		rst_ni        = 1'b0;
		start_i       = 1'b0;
		operator_i    = MD_OP_MULL;
		signed_mode_i = 2'b00;
		op_a_i        = '0;
		op_b_i        = '0;
		repeat (5) @(posedge clk_i);
		#1;
		rst_ni = 1'b1;

		fails_before = fail_cnt;
		@(negedge clk_i);
		check_eq(0, valid_o, "valid_o after reset");
		check_eq(0, busy_o, "busy_o after reset");
		check_eq(0, result_o, "result_o after reset");
		for (int i = 0; i < 16; i++) begin
			issue_op(MD_OP_MULL, 2'(i / 4), fixed_a[i % 4], fixed_b[i % 4],
				$sformatf("fixed mul %0d", i));
			wait_done();
		end
		for (int i = 0; i < MUL_OPS - 16; i++) begin
			issue_op(MD_OP_MULL, 2'(i), $random(seed), $random(seed),
				$sformatf("random mul %0d", i));
			wait_done();
		end
		report_test("1 reset and MUL", fails_before);

		fails_before = fail_cnt;
		for (int i = 0; i < DIV_OPS; i++) begin
			op = (i % 2) ? MD_OP_REM : MD_OP_DIV;
			a  = $random(seed);
			b  = $random(seed) >>> ($unsigned($random(seed)) % 24);  // vary divisor size
			issue_op(op, ((i / 2) % 2) ? 2'b11 : 2'b00, a, b, $sformatf("div/rem %0d", i));
			wait_done();
		end
		report_test("2 DIV and REM", fails_before);

		fails_before = fail_cnt;
		issue_op(MD_OP_DIV, 2'b00, $random(seed), '0, "div by zero unsigned");
		wait_done();
		issue_op(MD_OP_REM, 2'b11, $random(seed), '0, "rem by zero signed");
		wait_done();
		issue_op(MD_OP_DIV, 2'b11, 32'h8765_4321, '0, "div by zero signed");
		wait_done();
		issue_op(MD_OP_REM, 2'b00, 32'h8765_4321, '0, "rem by zero unsigned");
		wait_done();
		issue_op(MD_OP_DIV, 2'b11, 32'h8000_0000, 32'hffff_ffff, "overflow div");
		wait_done();
		issue_op(MD_OP_REM, 2'b11, 32'h8000_0000, 32'hffff_ffff, "overflow rem");
		wait_done();
		report_test("3 corner cases", fails_before);

		fails_before = fail_cnt;
		issue_op(MD_OP_DIV, 2'b11, 32'hf000_1234, 32'h0000_0345, "op before ignored start");
		repeat (3) @(posedge clk_i);
		#1;
		check_eq(1, busy_o, "busy_o during operation");
		start_i    = 1'b1;
		operator_i = MD_OP_MULL;
		op_a_i     = 32'h0000_1111;
		op_b_i     = 32'h0000_2222;
		@(posedge clk_i);
		#1;
		start_i = 1'b0;
		wait_done();
		@(posedge clk_i);
		#1;
		start_i    = 1'b1;
		operator_i = md_op_e'(2'b01);
		@(posedge clk_i);
		#1;
		start_i = 1'b0;
		seen    = 1'b0;
		repeat (40) begin
			@(negedge clk_i);
			if (busy_o || valid_o) begin
				seen = 1'b1;
			end
		end
		check_eq(0, seen, "reserved operator code started the unit");
		report_test("4 ignored starts", fails_before);

		fails_before = fail_cnt;
		for (int i = 0; i < HOLD_OPS; i++) begin
			op = (i % 2) ? MD_OP_REM : MD_OP_MULL;
			a  = $random(seed);
			b  = $random(seed);
			issue_op(op, 2'b11, a, b, $sformatf("hold op %0d", i));
			while (done_cnt != issued_cnt) begin
				@(posedge clk_i);
				#1;
				scramble_inputs();
			end
			repeat (4) begin
				@(negedge clk_i);
				check_eq(md_ref(op, 2'b11, a, b), result_o, "result held after valid_o");
			end
		end
		report_test("5 held result", fails_before);

		$display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
